/* aes_lite.f */
+incdir+include
design/aes_lite_pkg.sv
design/aes_dev_ctrl.sv
design/aes_step_counter.sv
design/aes_key_expander.sv
design/aes_round_key_store.sv
design/aes_round_datapath.sv
design/aes_device.sv
sim/aes_device_tb.sv

/* design/aes_dev_ctrl.sv */
// device FSM that sequences key generation, encryption and decryption for the cipher top level
`default_nettype none
`timescale 1ns/1ps

`include "aes_lite_macros.svh"

module aes_dev_ctrl
(
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     start,
    input  aes_lite_pkg::mode_t      mode,
    input  logic                     last,
    output aes_lite_pkg::step_ctrl_t ctrl,
    output logic                     take,
    output logic                     done,
    output logic                     keys_ready
);
    import aes_lite_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    mode_t       mode_q;
    logic        seed_word;
    logic        accept;
    logic        dec_op;

    // direction of the running operation
    assign dec_op = (mode_q == mode_dec);

    // start only counts in idle and cipher requests need a full key set
    always_comb
    begin
        accept = 1'b0;
        if (state == st_idle && start)
        begin
            case (mode)
                mode_keygen: accept = 1'b1;
                mode_enc:    accept = keys_ready;
                mode_dec:    accept = keys_ready;
                default:     accept = 1'b0;
            endcase
        end
    end

    always_comb
    begin
        state_nxt = state;
        ctrl = '0;
        ctrl.down = dec_op;
        case (state)
            st_idle:
            begin
                // keep the counter parked at the start index of whatever comes next
                ctrl.clear = 1'b1;
                ctrl.down = (mode == mode_dec);
                if (accept)
                    state_nxt = (mode == mode_keygen) ? st_seed : st_load;
            end
            st_seed:
            begin
                ctrl.seed_we = 1'b1;
                ctrl.step = 1'b1;
                if (seed_word == 1'(`AES_SEED_WORDS - 1))
                    state_nxt = st_expand;
            end
            st_expand:
            begin
                ctrl.key_we = 1'b1;
                ctrl.step = 1'b1;
                // key 14 written on this edge
                if (last)
                    state_nxt = st_idle;
            end
            st_load:
            begin
                ctrl.load = 1'b1;
                // decrypt consumed key 14 in the load and moves on to key 13
                ctrl.step = dec_op;
                state_nxt = st_round;
            end
            st_round:
            begin
                if (last && !dec_op)
                begin
                    // encrypt reached key 14 so the final xor goes out now
                    ctrl.emit = 1'b1;
                    state_nxt = st_idle;
                end
                else
                begin
                    ctrl.step = 1'b1;
                    // decrypt still runs round 0 at index 0
                    if (last)
                        state_nxt = st_emit;
                end
            end
            st_emit:
            begin
                ctrl.emit = 1'b1;
                state_nxt = st_idle;
            end
            default:
            begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state <= st_idle;
            mode_q <= mode_none;
            seed_word <= 1'b0;
            take <= 1'b0;
            done <= 1'b0;
            keys_ready <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            // take marks the cycles in which the inputs are consumed
            take <= (state_nxt == st_seed) || (state_nxt == st_load);
            done <= ctrl.emit;
            if (accept)
                mode_q <= mode;
            if (state == st_seed)
                seed_word <= seed_word + 1'b1;
            else
                seed_word <= 1'b0;
            // old keys are gone once the first seed word lands
            if (state == st_seed)
                keys_ready <= 1'b0;
            else if (state == st_expand && last)
                keys_ready <= 1'b1;
        end
    end

    // done is a single-cycle strobe
    done_pulse: assert property (@(posedge clk) disable iff (!resetn) done |=> !done);

    // take only in a consume cycle and a block load needs a full key set
    take_window: assert property (@(posedge clk) disable iff (!resetn)
        take |-> (ctrl.seed_we || (ctrl.load && keys_ready)));

endmodule

`default_nettype wire

/* design/aes_device.sv */
// top level of the lite cipher device, ties the controller, counter, key path and datapath together
`default_nettype none
`timescale 1ns/1ps

module aes_device
(
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 start,
    input  aes_lite_pkg::mode_t  mode,
    input  aes_lite_pkg::block_t data_in,
    input  aes_lite_pkg::block_t seed,
    output aes_lite_pkg::block_t data_out,
    output logic                 done,
    output logic                 take,
    output logic                 keys_ready
);
    import aes_lite_pkg::*;

    step_ctrl_t ctrl;
    key_idx_t   key_idx;
    logic       last;
    block_t     new_key;
    block_t     round_key;

    // sequencing
    aes_dev_ctrl ctrl_inst
    (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .mode       (mode),
        .last       (last),
        .ctrl       (ctrl),
        .take       (take),
        .done       (done),
        .keys_ready (keys_ready)
    );

    // shared round-key index
    aes_step_counter counter_inst
    (
        .clk     (clk),
        .resetn  (resetn),
        .ctrl    (ctrl),
        .key_idx (key_idx),
        .last    (last)
    );

    aes_key_expander expander_inst
    (
        .clk     (clk),
        .resetn  (resetn),
        .ctrl    (ctrl),
        .seed    (seed),
        .key_idx (key_idx),
        .new_key (new_key)
    );

    aes_round_key_store store_inst
    (
        .clk       (clk),
        .resetn    (resetn),
        .ctrl      (ctrl),
        .key_idx   (key_idx),
        .new_key   (new_key),
        .round_key (round_key)
    );

    // block path
    aes_round_datapath datapath_inst
    (
        .clk       (clk),
        .resetn    (resetn),
        .ctrl      (ctrl),
        .data_in   (data_in),
        .round_key (round_key),
        .data_out  (data_out)
    );

endmodule

`default_nettype wire

/* design/aes_key_expander.sv */
// round-key generator that turns the two seed words into keys 2 to 14, one key per cycle
`default_nettype none
`timescale 1ns/1ps

`include "aes_lite_macros.svh"

module aes_key_expander
(
    input  logic                     clk,
    input  logic                     resetn,
    input  aes_lite_pkg::step_ctrl_t ctrl,
    input  aes_lite_pkg::block_t     seed,
    input  aes_lite_pkg::key_idx_t   key_idx,
    output aes_lite_pkg::block_t     new_key
);
    import aes_lite_pkg::*;

    block_t     prev_1;
    block_t     prev_2;
    block_t     rot_key;
    block_t     next_key;
    logic [7:0] rcon;
    logic       shift_en;

    assign shift_en = ctrl.seed_we | ctrl.key_we;

    // recurrence on key i-1 and key i-2
    always_comb
    begin
        // rotate left by one byte
        rot_key = {prev_1[`AES_BLOCK_W-9:0], prev_1[`AES_BLOCK_W-1 -: 8]};
        rot_key[`AES_BLOCK_W-1 -: 8] = rot_key[`AES_BLOCK_W-1 -: 8] ^ rcon;
        if (key_idx[0])
            next_key = prev_1 ^ prev_2;
        else
            next_key = rot_key ^ prev_2;
    end

    // first keys come straight from the seed
    assign new_key = (key_idx < `AES_SEED_WORDS) ? seed : next_key;

    // two-deep key history
    always_ff @(posedge clk)
    begin
        if (shift_en)
        begin
            prev_2 <= prev_1;
            prev_1 <= new_key;
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            rcon <= 8'h01;
        end
        else if (ctrl.seed_we)
        begin
            rcon <= 8'h01;
        end
        else if (ctrl.key_we && !key_idx[0])
        begin
            // xtime, reduce by x^8+x^4+x^3+x+1
            rcon <= {rcon[6:0], 1'b0} ^ (rcon[7] ? 8'h1b : 8'h00);
        end
    end

endmodule

`default_nettype wire

/* design/aes_lite_pkg.sv */
// shared types of the lite cipher device, imported by every RTL module
`default_nettype none

`include "aes_lite_macros.svh"

package aes_lite_pkg;

    // one data block or one round key
    typedef logic [`AES_BLOCK_W-1:0] block_t;

    // round key index into the key store
    typedef logic [`AES_KEY_IDX_W-1:0] key_idx_t;

    // operation code sampled together with start
    typedef enum logic [1:0]
    {
        mode_enc    = 2'b00,
        mode_dec    = 2'b01,
        mode_keygen = 2'b10,
        mode_none   = 2'b11
    } mode_t;

    // device controller states
    typedef enum logic [3-1:0]
    {
        st_idle,
        st_seed,
        st_expand,
        st_load,
        st_round,
        st_emit
    } ctrl_state_t;

    // strobes from the controller to counter, expander, store and datapath
    typedef struct packed
    {
        logic clear;
        logic down;
        logic step;
        logic seed_we;
        logic key_we;
        logic load;
        logic emit;
    } step_ctrl_t;

endpackage

`default_nettype wire

/* design/aes_round_datapath.sv */
// cipher state register with ShiftRows or inverse ShiftRows and key xor, plus the output register
`default_nettype none
`timescale 1ns/1ps

`include "aes_lite_macros.svh"

module aes_round_datapath
(
    input  logic                     clk,
    input  logic                     resetn,
    input  aes_lite_pkg::step_ctrl_t ctrl,
    input  aes_lite_pkg::block_t     data_in,
    input  aes_lite_pkg::block_t     round_key,
    output aes_lite_pkg::block_t     data_out
);
    import aes_lite_pkg::*;

    block_t state_q;

    // byte n of the block sits at the top, column-major state with s[r][c] = byte r+4c
    function automatic block_t shift_rows(block_t b);
        block_t r;
        for (int c = 0; c < 4; c++)
        begin
            for (int row = 0; row < 4; row++)
            begin
                // row r rotates left by r columns
                r[`AES_BLOCK_W-1 - 8*(row + 4*c) -: 8] =
                    b[`AES_BLOCK_W-1 - 8*(row + 4*((c + row) % 4)) -: 8];
            end
        end
        return r;
    endfunction

    function automatic block_t inv_shift_rows(block_t b);
        block_t r;
        for (int c = 0; c < 4; c++)
        begin
            for (int row = 0; row < 4; row++)
            begin
                // rotate right by r columns
                r[`AES_BLOCK_W-1 - 8*(row + 4*c) -: 8] =
                    b[`AES_BLOCK_W-1 - 8*(row + 4*((c + 4 - row) % 4)) -: 8];
            end
        end
        return r;
    endfunction

    // state register, load wins over step
    always_ff @(posedge clk)
    begin
        if (ctrl.load)
        begin
            // decrypt starts by removing key 14
            state_q <= ctrl.down ? (data_in ^ round_key) : data_in;
        end
        else if (ctrl.step)
        begin
            if (ctrl.down)
                state_q <= inv_shift_rows(state_q) ^ round_key;
            else
                state_q <= shift_rows(state_q ^ round_key);
        end
    end

    // result register, holds until the next emit
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            data_out <= '0;
        end
        else if (ctrl.emit)
        begin
            // encrypt still owes the last key
            data_out <= ctrl.down ? state_q : (state_q ^ round_key);
        end
    end

endmodule

`default_nettype wire

/* design/aes_round_key_store.sv */
// round-key register file, written during key generation and read by the datapath each round
`default_nettype none
`timescale 1ns/1ps

`include "aes_lite_macros.svh"

module aes_round_key_store
(
    input  logic                     clk,
    input  logic                     resetn,
    input  aes_lite_pkg::step_ctrl_t ctrl,
    input  aes_lite_pkg::key_idx_t   key_idx,
    input  aes_lite_pkg::block_t     new_key,
    output aes_lite_pkg::block_t     round_key
);
    import aes_lite_pkg::*;

    block_t slots [`AES_KEY_SLOTS];
    logic   wr_en;

    // seed words and expanded keys share the write port
    assign wr_en = ctrl.seed_we | ctrl.key_we;

    always_ff @(posedge clk)
    begin
        if (wr_en)
            slots[key_idx] <= new_key;
    end

    // combinational read at the counter index
    assign round_key = slots[key_idx];

    // top slot is spare, counter must never point a write there
    no_spare_write: assert property (@(posedge clk) disable iff (!resetn)
        wr_en |-> (key_idx != key_idx_t'(`AES_KEY_SLOTS - 1)));

endmodule

`default_nettype wire

/* design/aes_step_counter.sv */
// up/down round-key index counter with a terminal flag for the cipher controller
`default_nettype none
`timescale 1ns/1ps

`include "aes_lite_macros.svh"

module aes_step_counter
(
    input  logic                     clk,
    input  logic                     resetn,
    input  aes_lite_pkg::step_ctrl_t ctrl,
    output aes_lite_pkg::key_idx_t   key_idx,
    output logic                     last
);
    import aes_lite_pkg::*;

    // index of the final round key
    localparam key_idx_t top_idx = key_idx_t'(`AES_ROUND_KEYS - 1);

    // terminal index depends on direction
    assign last = ctrl.down ? (key_idx == '0) : (key_idx == top_idx);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            key_idx <= '0;
        end
        else if (ctrl.clear)
        begin
            key_idx <= ctrl.down ? top_idx : '0;
        end
        else if (ctrl.step && !last)
        begin
            // hold at the terminal index
            key_idx <= ctrl.down ? key_idx - 1'b1 : key_idx + 1'b1;
        end
    end

    // index must stay inside the written part of the key store
    idx_range: assert property (@(posedge clk) disable iff (!resetn) key_idx <= top_idx);

endmodule

`default_nettype wire

/* include/aes_lite_macros.svh */
// width and depth constants for the lite block cipher, included by the package and the RTL
`ifndef AES_LITE_MACROS_SVH
`define AES_LITE_MACROS_SVH

// data block and round key share one width
`define AES_BLOCK_W     128

// keys 0..14, one per round plus the final whitening key
`define AES_ROUND_KEYS  15

// store is a power of two, top slot never written
`define AES_KEY_SLOTS   16

// enough bits to address every slot
`define AES_KEY_IDX_W   4

// seed arrives as two full blocks, keys 0 and 1
`define AES_SEED_WORDS  2

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cipher device testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module aes_device_tb -f aes_lite.f

out=$(./obj_dir/Vaes_device_tb 2>&1 || true)
echo "$out"

if grep -qx "NO ERRORS" <<< "$out"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* sim/aes_device_tb.sv */
// directed testbench for the lite cipher device, compiled with the RTL and run as top aes_device_tb
`default_nettype none
`timescale 1ns/1ps

`include "aes_lite_macros.svh"

module aes_device_tb;
    import aes_lite_pkg::*;

    logic   clk;
    logic   resetn;
    logic   start;
    mode_t  mode;
    block_t data_in;
    block_t seed;
    block_t data_out;
    logic   done;
    logic   take;
    logic   keys_ready;

    int     seed_var = 30617;

    // expected round keys, rebuilt on every key generation
    block_t mk [`AES_ROUND_KEYS];

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    aes_device aes_device_inst
    (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .mode       (mode),
        .data_in    (data_in),
        .seed       (seed),
        .data_out   (data_out),
        .done       (done),
        .take       (take),
        .keys_ready (keys_ready)
    );

    function automatic block_t rand_block();
        return {$random(seed_var), $random(seed_var), $random(seed_var), $random(seed_var)};
    endfunction

    // byte n at the top of the block, row n%4 and column n/4
    function automatic block_t rows_shift(block_t b, bit inv);
        logic [7:0] s [16];
        block_t     r;
        int         src;
        for (int n = 0; n < 16; n++)
            s[n] = b[127 - 8*n -: 8];
        for (int n = 0; n < 16; n++)
        begin
            // forward pulls from column c+row, inverse from column c-row
            if (inv)
                src = (n % 4) + 4*((n / 4 + 4 - n % 4) % 4);
            else
                src = (n % 4) + 4*((n / 4 + n % 4) % 4);
            r[127 - 8*n -: 8] = s[src];
        end
        return r;
    endfunction

    task automatic model_keygen(input block_t w0, input block_t w1);
        logic [7:0] rc;
        block_t     t;
        rc = 8'h01;
        mk[0] = w0;
        mk[1] = w1;
        for (int i = 2; i < `AES_ROUND_KEYS; i++)
        begin
            if (i % 2 == 0)
            begin
                // byte rotate, rcon into the top byte
                t = {mk[i-1][119:0], mk[i-1][127:120]};
                t[127:120] = t[127:120] ^ rc;
                mk[i] = t ^ mk[i-2];
                rc = {rc[6:0], 1'b0} ^ (rc[7] ? 8'h1b : 8'h00);
            end
            else
                mk[i] = mk[i-1] ^ mk[i-2];
        end
    endtask

    function automatic block_t model_enc(block_t p);
        block_t s;
        s = p;
        for (int r = 0; r < 14; r++)
            s = rows_shift(s ^ mk[r], 1'b0);
        return s ^ mk[14];
    endfunction

    function automatic block_t model_dec(block_t c);
        block_t s;
        s = c ^ mk[14];
        for (int r = 13; r >= 0; r--)
            s = rows_shift(s, 1'b1) ^ mk[r];
        return s;
    endfunction

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_block(input block_t got, input block_t exp, input string what);
        if (got !== exp)
        begin
            $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("error at %0t: %s got %b expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    // cipher request without keys, must be dropped
    task automatic request_without_keys(input block_t blk);
        @(posedge clk);
        start <= 1'b1;
        mode <= mode_enc;
        data_in <= blk;
        for (int k = 0; k < 40; k++)
        begin
            @(negedge clk);
            check_flag(take, 1'b0, "take before any keys");
            check_flag(done, 1'b0, "done before any keys");
        end
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic run_keygen(input block_t w0, input block_t w1);
        int   k;
        int   n_take;
        int   widx;
        logic took;
        logic saw_low;
        logic ready;
        k = 0;
        n_take = 0;
        widx = 0;
        saw_low = 1'b0;
        ready = 1'b0;
        @(posedge clk);
        start <= 1'b1;
        mode <= mode_keygen;
        seed <= w0;
        // accept edge
        @(posedge clk);
        start <= 1'b0;
        while (!ready && k <= 40)
        begin
            @(negedge clk);
            took = take;
            if (took)
                n_take++;
            if (!keys_ready)
                saw_low = 1'b1;
            ready = saw_low && keys_ready;
            if (!ready)
            begin
                @(posedge clk);
                // word taken on this edge, present the next one
                if (took)
                begin
                    widx++;
                    seed <= (widx == 1) ? w1 : rand_block();
                end
                k++;
            end
        end
        if (!ready)
        begin
            $display("timed out waiting for keys_ready after key generation");
            stop_run();
        end
        else
        begin
            check_flag(k == 15, 1'b1, "keys_ready 15 cycles after accept");
            check_flag(n_take == 2, 1'b1, "take high on two cycles");
            model_keygen(w0, w1);
        end
    endtask

    // called right after the accept edge, optional stray start and back-to-back request
    task automatic await_done(input block_t exp, input bit poke, input bit hold_next,
                              input mode_t nm, input block_t nb);
        int     k;
        int     n_take;
        logic   took;
        logic   fin;
        block_t got;
        k = 0;
        n_take = 0;
        fin = 1'b0;
        got = '0;
        while (!fin && k <= 40)
        begin
            @(negedge clk);
            took = take;
            fin = done;
            got = data_out;
            if (took)
                n_take++;
            check_flag(keys_ready, 1'b1, "keys_ready during cipher op");
            @(posedge clk);
            if (took)
                data_in <= rand_block();
            // keygen strobe mid-run would wipe the keys if taken
            if (poke && k == 4)
            begin
                start <= 1'b1;
                mode <= mode_keygen;
            end
            if (poke && k == 5)
                start <= 1'b0;
            // held on into the done cycle
            if (hold_next && k == 9)
            begin
                start <= 1'b1;
                mode <= nm;
                data_in <= nb;
            end
            if (!fin)
                k++;
        end
        if (!fin)
        begin
            $display("timed out waiting for done from a cipher op");
            stop_run();
        end
        else
        begin
            // with start held this edge was the next accept
            start <= 1'b0;
            check_flag(k == 16, 1'b1, "done 16 cycles after accept");
            check_flag(n_take == 1, 1'b1, "take high on one cycle");
            check_block(got, exp, "data_out");
        end
    endtask

    task automatic cipher_op(input mode_t m, input block_t blk, input block_t exp,
                             input bit poke, input bit hold_next, input mode_t nm,
                             input block_t nb);
        @(posedge clk);
        start <= 1'b1;
        mode <= m;
        data_in <= blk;
        @(posedge clk);
        start <= 1'b0;
        await_done(exp, poke, hold_next, nm, nb);
    endtask

    initial
    begin
        block_t p;
        block_t c;
        block_t plain [4];
        block_t ciph [4];
        resetn = 1'b0;
        start = 1'b0;
        mode = mode_enc;
        data_in = '0;
        seed = '0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);

        // reset values, then a request with no keys
        check_block(data_out, '0, "data_out after reset");
        check_flag(done, 1'b0, "done after reset");
        check_flag(take, 1'b0, "take after reset");
        check_flag(keys_ready, 1'b0, "keys_ready after reset");
        request_without_keys(rand_block());

        run_keygen(rand_block(), rand_block());

        // encrypt, then decrypt the same ciphertexts back
        for (int i = 0; i < 4; i++)
        begin
            plain[i] = rand_block();
            ciph[i] = model_enc(plain[i]);
            cipher_op(mode_enc, plain[i], ciph[i], 1'b0, 1'b0, mode_none, '0);
        end
        for (int i = 0; i < 4; i++)
            cipher_op(mode_dec, ciph[i], plain[i], 1'b0, 1'b0, mode_none, '0);
        for (int i = 0; i < 3; i++)
        begin
            c = rand_block();
            cipher_op(mode_dec, c, model_dec(c), 1'b0, 1'b0, mode_none, '0);
        end

        // stray start, then a decrypt chained from the done cycle
        p = rand_block();
        c = rand_block();
        cipher_op(mode_enc, p, model_enc(p), 1'b1, 1'b1, mode_dec, c);
        await_done(model_dec(c), 1'b0, 1'b0, mode_none, '0);

        // fresh seed
        run_keygen(rand_block(), rand_block());
        c = model_enc(plain[0]);
        check_flag(c !== ciph[0], 1'b1, "ciphertext differs under new keys");
        cipher_op(mode_enc, plain[0], c, 1'b0, 1'b0, mode_none, '0);
        cipher_op(mode_dec, c, plain[0], 1'b0, 1'b0, mode_none, '0);

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
